// ==== usb_desc_pkg.sv ====
// USB descriptor parser
// Shared types and descriptor layout
`default_nettype none

package usb_desc_pkg;

    // Plain data widths
    typedef logic [7:0]  desc_byte_t;
    typedef logic [7:0]  desc_index_t;
    typedef logic [15:0] usb_id_t;

    // Parser sequencing
    typedef enum logic [2:0] {
        PARSE_IDLE,
        PARSE_LENGTH,
        PARSE_TYPE,
        PARSE_FIELDS,
        PARSE_DONE
    } parse_state_e;

    // One-hot byte-kind strobes, high only when a byte is accepted
    typedef struct packed {
        logic take_length;
        logic take_type;
        logic take_field;
    } parse_strobe_t;

    // Extracted device descriptor fields, 56 bits
    typedef struct packed {
        usb_id_t    vendor_id;
        usb_id_t    product_id;
        desc_byte_t device_class;
        desc_byte_t max_packet_size;
        desc_byte_t num_configurations;
    } device_info_t;

    // bDescriptorType of a device descriptor
    localparam desc_byte_t DEVICE_DESC_TYPE = 8'h01;

    // Standard device descriptor offsets
    localparam desc_index_t OFFS_CLASS       = 8'd4;
    localparam desc_index_t OFFS_MAX_PACKET  = 8'd7;
    // Low byte of each ID, high byte follows directly
    localparam desc_index_t OFFS_VENDOR_LO   = 8'd8;
    localparam desc_index_t OFFS_PRODUCT_LO  = 8'd10;
    localparam desc_index_t OFFS_NUM_CONFIGS = 8'd17;

endpackage

`default_nettype wire

// ==== desc_parse_fsm.sv ====
// Descriptor parse sequencer
`timescale 1ns/1ps
`default_nettype none

module desc_parse_fsm
    import usb_desc_pkg::*;
(
    input  wire             clk,
    input  wire             reset,
    input  wire             data_valid,
    input  wire             start_parse,
    input  wire desc_byte_t desc_length,
    input  wire             last_byte,
    output parse_strobe_t   strobes,
    output parse_state_e    parse_state,
    output logic            parsing_complete
);

    parse_state_e state_next;
    logic         short_header;
    logic         type_is_last;

    // Length 0..2 means nothing follows the type byte
    assign short_header = (desc_length < 8'd3);
    assign type_is_last = last_byte || short_header;

    // Byte kind follows the state; a byte in PARSE_LENGTH is already the type
    always_comb begin
        strobes = '0;
        case (parse_state)
            PARSE_IDLE: begin
                strobes.take_length = start_parse && data_valid;
            end
            PARSE_LENGTH, PARSE_TYPE: begin
                strobes.take_type = data_valid;
            end
            PARSE_FIELDS: begin
                strobes.take_field = data_valid;
            end
            default: begin
                strobes = '0;
            end
        endcase
    end

    always_comb begin
        state_next = parse_state;
        case (parse_state)
            PARSE_IDLE: begin
                if (strobes.take_length) begin
                    state_next = PARSE_LENGTH;
                end
            end
            PARSE_LENGTH: begin
                // bLength is registered by now
                if (strobes.take_type) begin
                    state_next = type_is_last ? PARSE_DONE : PARSE_FIELDS;
                end else begin
                    state_next = PARSE_TYPE;
                end
            end
            PARSE_TYPE: begin
                if (strobes.take_type) begin
                    state_next = type_is_last ? PARSE_DONE : PARSE_FIELDS;
                end
            end
            PARSE_FIELDS: begin
                if (strobes.take_field && last_byte) begin
                    state_next = PARSE_DONE;
                end
            end
            PARSE_DONE: begin
                state_next = PARSE_IDLE;
            end
            default: begin
                state_next = PARSE_IDLE;
            end
        endcase
    end

    // Completion pulse lines up with the PARSE_DONE cycle
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            parse_state      <= PARSE_IDLE;
            parsing_complete <= 1'b0;
        end else begin
            parse_state      <= state_next;
            parsing_complete <= (state_next == PARSE_DONE);
        end
    end

endmodule

`default_nettype wire

// ==== desc_byte_counter.sv ====
// Descriptor byte offset counter
`timescale 1ns/1ps
`default_nettype none

module desc_byte_counter
    import usb_desc_pkg::*;
(
    input  wire                clk,
    input  wire                reset,
    input  wire parse_strobe_t strobes,
    input  wire desc_byte_t    desc_length,
    output desc_index_t        field_index,
    output logic               last_byte
);

    logic accepting;
    logic short_header;

    assign accepting    = strobes.take_type || strobes.take_field;
    assign short_header = (desc_length < 8'd3);

    // Offset of the byte that the next strobe accepts
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            field_index <= '0;
        end else if (strobes.take_length) begin
            field_index <= 8'd1;
        end else if (accepting) begin
            field_index <= field_index + 8'd1;
        end
    end

    // Short descriptors end on the type byte at offset 1
    always_comb begin
        if (!accepting) begin
            last_byte = 1'b0;
        end else if (short_header) begin
            last_byte = strobes.take_type;
        end else begin
            last_byte = (field_index == desc_length - 8'd1);
        end
    end

endmodule

`default_nettype wire

// ==== desc_header_capture.sv ====
// Descriptor header registers
`timescale 1ns/1ps
`default_nettype none

module desc_header_capture
    import usb_desc_pkg::*;
(
    input  wire                clk,
    input  wire                reset,
    input  wire desc_byte_t    data_in,
    input  wire parse_strobe_t strobes,
    output desc_byte_t         desc_length,
    output desc_byte_t         desc_type
);

    // bLength, held until the next descriptor starts
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            desc_length <= '0;
        end else if (strobes.take_length) begin
            desc_length <= data_in;
        end
    end

    // bDescriptorType
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            desc_type <= '0;
        end else if (strobes.take_type) begin
            desc_type <= data_in;
        end
    end

endmodule

`default_nettype wire

// ==== device_field_extract.sv ====
// Device descriptor field extraction
`timescale 1ns/1ps
`default_nettype none

module device_field_extract
    import usb_desc_pkg::*;
(
    input  wire              clk,
    input  wire              reset,
    input  wire desc_byte_t  data_in,
    input  wire              take_field,
    input  wire desc_index_t field_index,
    input  wire desc_byte_t  desc_type,
    output device_info_t     device_info
);

    logic is_device;
    logic write_en;

    // Type byte is registered before any field byte arrives
    assign is_device = (desc_type == DEVICE_DESC_TYPE);
    assign write_en  = take_field && is_device;

    // One byte lane per offset, IDs little endian
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            device_info <= '0;
        end else if (write_en) begin
            case (field_index)
                OFFS_CLASS: begin
                    device_info.device_class <= data_in;
                end
                OFFS_MAX_PACKET: begin
                    device_info.max_packet_size <= data_in;
                end
                OFFS_VENDOR_LO: begin
                    device_info.vendor_id[7:0] <= data_in;
                end
                desc_index_t'(OFFS_VENDOR_LO + 8'd1): begin
                    device_info.vendor_id[15:8] <= data_in;
                end
                OFFS_PRODUCT_LO: begin
                    device_info.product_id[7:0] <= data_in;
                end
                desc_index_t'(OFFS_PRODUCT_LO + 8'd1): begin
                    device_info.product_id[15:8] <= data_in;
                end
                OFFS_NUM_CONFIGS: begin
                    device_info.num_configurations <= data_in;
                end
                default: begin
                    // Reserved and bcd fields are skipped
                    device_info <= device_info;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== usb_descriptor_parser.sv ====
// USB standard descriptor parser
`timescale 1ns/1ps
`default_nettype none

module usb_descriptor_parser
    import usb_desc_pkg::*;
(
    input  wire             clk,
    input  wire             reset,
    input  wire desc_byte_t data_in,
    input  wire             data_valid,
    input  wire             start_parse,
    output device_info_t    device_info,
    output desc_byte_t      desc_type,
    output logic            parsing_complete,
    output parse_state_e    parse_state
);

    parse_strobe_t strobes;
    desc_byte_t    desc_length;
    desc_index_t   field_index;
    logic          last_byte;

    desc_parse_fsm desc_parse_fsm_inst (
        .clk              (clk),
        .reset            (reset),
        .data_valid       (data_valid),
        .start_parse      (start_parse),
        .desc_length      (desc_length),
        .last_byte        (last_byte),
        .strobes          (strobes),
        .parse_state      (parse_state),
        .parsing_complete (parsing_complete)
    );

    desc_byte_counter desc_byte_counter_inst (
        .clk         (clk),
        .reset       (reset),
        .strobes     (strobes),
        .desc_length (desc_length),
        .field_index (field_index),
        .last_byte   (last_byte)
    );

    desc_header_capture desc_header_capture_inst (
        .clk         (clk),
        .reset       (reset),
        .data_in     (data_in),
        .strobes     (strobes),
        .desc_length (desc_length),
        .desc_type   (desc_type)
    );

    // Only field bytes reach the extractor
    device_field_extract device_field_extract_inst (
        .clk         (clk),
        .reset       (reset),
        .data_in     (data_in),
        .take_field  (strobes.take_field),
        .field_index (field_index),
        .desc_type   (desc_type),
        .device_info (device_info)
    );

endmodule

`default_nettype wire

// ==== usb_descriptor_parser_sva.sv ====
// Parse sequencer assertions
`timescale 1ns/1ps
`default_nettype none

module usb_descriptor_parser_sva
    import usb_desc_pkg::*;
(
    input wire                clk,
    input wire                reset,
    input wire                data_valid,
    input wire parse_strobe_t strobes,
    input wire parse_state_e  parse_state,
    input wire                parsing_complete
);

    logic [2:0] strobe_bits;

    assign strobe_bits = {strobes.take_length, strobes.take_type, strobes.take_field};

    one_strobe_a: assert property (@(posedge clk) disable iff (reset)
        $onehot0(strobe_bits))
        else $error("more than one strobe high: %b", strobe_bits);

    // Completion is a single-cycle pulse
    complete_pulse_a: assert property (@(posedge clk) disable iff (reset)
        parsing_complete |=> !parsing_complete)
        else $error("parsing_complete high for more than one cycle");

    done_to_idle_a: assert property (@(posedge clk) disable iff (reset)
        parse_state == PARSE_DONE |=> parse_state == PARSE_IDLE)
        else $error("PARSE_DONE not followed by PARSE_IDLE");

    strobe_needs_valid_a: assert property (@(posedge clk) disable iff (reset)
        !data_valid |-> strobe_bits == 3'b000)
        else $error("strobe high without data_valid");

endmodule

bind desc_parse_fsm usb_descriptor_parser_sva usb_descriptor_parser_sva_inst (
    .clk              (clk),
    .reset            (reset),
    .data_valid       (data_valid),
    .strobes          (strobes),
    .parse_state      (parse_state),
    .parsing_complete (parsing_complete)
);

`default_nettype wire

// ==== tb_usb_descriptor_parser.sv ====
// USB descriptor parser testbench
`timescale 1ns/1ps
`default_nettype none

module tb_usb_descriptor_parser
    import usb_desc_pkg::*;
();

    logic         clk;
    logic         reset;
    desc_byte_t   data_in;
    logic         data_valid;
    logic         start_parse;
    device_info_t device_info;
    desc_byte_t   desc_type;
    logic         parsing_complete;
    parse_state_e parse_state;

    // Stimulus words and the record being replayed
    logic [15:0]  stim_mem [0:511];
    desc_byte_t   desc_bytes [0:63];
    logic [15:0]  record_mode;
    int           record_count;
    int           stim_ptr;
    int           record_total;
    logic [31:0]  lfsr_state;

    desc_byte_t   exp_type;
    usb_id_t      exp_vendor;
    usb_id_t      exp_product;
    desc_byte_t   exp_class;
    desc_byte_t   exp_max_packet;
    desc_byte_t   exp_num_configs;

    usb_descriptor_parser usb_descriptor_parser_inst (
        .clk              (clk),
        .reset            (reset),
        .data_in          (data_in),
        .data_valid       (data_valid),
        .start_parse      (start_parse),
        .device_info      (device_info),
        .desc_type        (desc_type),
        .parsing_complete (parsing_complete),
        .parse_state      (parse_state)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Result: FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_id(input usb_id_t actual, input usb_id_t expected, input string name);
        if (actual !== expected) begin
            abort_run($sformatf("mismatch at %0t ns: %s is %h, expected %h",
                $time, name, actual, expected));
        end
    endtask

    task automatic check_byte(input desc_byte_t actual, input desc_byte_t expected,
                              input string name);
        if (actual !== expected) begin
            abort_run($sformatf("mismatch at %0t ns: %s is %h, expected %h",
                $time, name, actual, expected));
        end
    endtask

    task automatic check_state(input parse_state_e actual, input parse_state_e expected,
                               input string name);
        if (actual !== expected) begin
            abort_run($sformatf("mismatch at %0t ns: %s is %s, expected %s",
                $time, name, actual.name(), expected.name()));
        end
    endtask

    task automatic expect_no_pulse(input string where);
        if (parsing_complete !== 1'b0) begin
            abort_run($sformatf("parsing_complete pulsed %s at %0t ns", where, $time));
        end
    endtask

    // Inputs change 1 ns after the edge, outputs are settled there
    task automatic advance();
        @(posedge clk);
        #1;
    endtask

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        logic feedback;
        feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
        return {state[30:0], feedback};
    endfunction

    // Two bits, one LFSR step each
    function automatic int draw_gap();
        int gap;
        int i;
        gap = 0;
        for (i = 0; i < 2; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            gap = {gap[30:0], lfsr_state[0]};
        end
        return gap;
    endfunction

    task automatic wait_for_complete(input int limit);
        int waited;
        waited = 0;
        while (parsing_complete !== 1'b1) begin
            if (waited >= limit) begin
                abort_run("timeout while waiting for parsing_complete");
            end
            advance();
            waited++;
        end
    endtask

    task automatic load_record();
        int i;
        if (stim_ptr + 8 > $size(stim_mem)) begin
            abort_run("stimulus file has no end marker");
        end
        record_mode  = stim_mem[stim_ptr];
        record_count = int'(stim_mem[stim_ptr + 1]);
        if (record_count < 1 || record_count > 64 ||
            stim_ptr + record_count + 8 > $size(stim_mem)) begin
            abort_run($sformatf("bad byte count %0d in stimulus record", record_count));
        end
        stim_ptr += 2;
        for (i = 0; i < record_count; i++) begin
            desc_bytes[i] = stim_mem[stim_ptr + i][7:0];
        end
        stim_ptr += record_count;
        exp_type        = stim_mem[stim_ptr][7:0];
        exp_vendor      = stim_mem[stim_ptr + 1];
        exp_product     = stim_mem[stim_ptr + 2];
        exp_class       = stim_mem[stim_ptr + 3][7:0];
        exp_max_packet  = stim_mem[stim_ptr + 4][7:0];
        exp_num_configs = stim_mem[stim_ptr + 5][7:0];
        stim_ptr += 6;
    endtask

    task automatic check_results();
        check_state(parse_state, PARSE_DONE, "parse_state");
        check_byte(desc_type, exp_type, "desc_type");
        check_id(device_info.vendor_id, exp_vendor, "device_info.vendor_id");
        check_id(device_info.product_id, exp_product, "device_info.product_id");
        check_byte(device_info.device_class, exp_class, "device_info.device_class");
        check_byte(device_info.max_packet_size, exp_max_packet, "device_info.max_packet_size");
        check_byte(device_info.num_configurations, exp_num_configs,
            "device_info.num_configurations");
        // IDs straight from the raw bytes, low byte first
        if (exp_type == DEVICE_DESC_TYPE) begin
            check_id(device_info.vendor_id, {desc_bytes[9], desc_bytes[8]},
                "vendor_id from bytes 8 and 9");
            check_id(device_info.product_id, {desc_bytes[11], desc_bytes[10]},
                "product_id from bytes 10 and 11");
        end
    endtask

    // Mode 0 inserts random gaps, mode 1 runs without any
    task automatic send_record();
        int i;
        int gap;
        for (i = 0; i < record_count; i++) begin
            gap = (record_mode == 16'h0000) ? draw_gap() : 0;
            data_valid = 1'b0;
            repeat (gap) begin
                advance();
                expect_no_pulse("during an input gap");
            end
            data_in    = desc_bytes[i];
            data_valid = 1'b1;
            advance();
            if (i < record_count - 1) begin
                expect_no_pulse("before the last byte");
            end
        end
        data_valid = 1'b0;
        data_in    = '0;
        wait_for_complete(8);
        check_results();
        advance();
        expect_no_pulse("in the cycle after completion");
        check_state(parse_state, PARSE_IDLE, "parse_state after completion");
    endtask

    initial begin
        reset        = 1'b1;
        data_in      = '0;
        data_valid   = 1'b0;
        start_parse  = 1'b0;
        lfsr_state   = 32'h2793;
        stim_ptr     = 0;
        record_total = 0;
        $readmemh("desc_stimulus.txt", stim_mem);

        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;

        check_state(parse_state, PARSE_IDLE, "parse_state after reset");
        check_byte(desc_type, 8'h00, "desc_type after reset");
        check_id(device_info.vendor_id, 16'h0000, "vendor_id after reset");
        check_id(device_info.product_id, 16'h0000, "product_id after reset");
        check_byte(device_info.device_class, 8'h00, "device_class after reset");
        check_byte(device_info.max_packet_size, 8'h00, "max_packet_size after reset");
        check_byte(device_info.num_configurations, 8'h00, "num_configurations after reset");
        expect_no_pulse("after reset");

        // Parser not armed, bytes must be dropped
        data_in    = 8'h12;
        data_valid = 1'b1;
        repeat (4) begin
            advance();
            expect_no_pulse("with start_parse low");
            check_state(parse_state, PARSE_IDLE, "parse_state with start_parse low");
        end
        data_valid  = 1'b0;
        start_parse = 1'b1;

        while (stim_mem[stim_ptr] != 16'hffff) begin
            load_record();
            send_record();
            record_total++;
        end
        if (record_total == 0) begin
            abort_run("stimulus file holds no records");
        end

        repeat (4) begin
            advance();
            expect_no_pulse("after the last descriptor");
        end
        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== desc_stimulus.txt ====
// Record: mode, byte count (hex), descriptor bytes; then the expected line
// type, idVendor, idProduct, class, max packet, configurations; ffff ends
// Mode 0 uses random gaps, mode 1 starts right after the previous completion
0 12 12 01 00 02 ef 02 01 40 8a 04 5b c0 00 01 01 02 03 01
01 048a c05b ef 40 01
// Configuration descriptor, device fields stay
0 09 09 02 20 00 01 01 00 80 32
02 048a c05b ef 40 01
// String descriptor zero
0 04 04 03 09 04
03 048a c05b ef 40 01
// Back to back, bLength 2 ends on the type byte
1 02 02 05
05 048a c05b ef 40 01
1 12 12 01 10 02 00 00 00 08 83 04 40 57 00 02 01 02 00 02
01 0483 5740 00 08 02
// bLength 0 also ends on the type byte
1 02 00 09
09 0483 5740 00 08 02
// Endpoint descriptor
0 07 07 05 81 03 08 00 0a
05 0483 5740 00 08 02
0 12 12 01 00 02 ff 00 00 20 d2 04 e1 1a 00 01 00 00 00 03
01 04d2 1ae1 ff 20 03
ffff

// ==== all.f ====
usb_desc_pkg.sv
desc_parse_fsm.sv
desc_byte_counter.sv
desc_header_capture.sv
device_field_extract.sv
usb_descriptor_parser.sv
usb_descriptor_parser_sva.sv
tb_usb_descriptor_parser.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the USB descriptor parser testbench with Verilator
rm -f sim.log
verilator --binary --assert -f all.f --top-module tb_usb_descriptor_parser -o sim_tb \
    || { echo "Build failed"; exit 1; }
./obj_dir/sim_tb > sim.log 2>&1
cat sim.log
grep -q "Result: PASSED" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed, see sim.log"; exit 1; }
